// File: src/font.hex
// one glyph per line: 64 bits, row 0 in the top byte, leftmost pixel in the high bit
0000000000000000
FFFFFFFFFFFFFFFF
183C66667E666600
7C66667C66667C00
3C66606060663C00
786C6666666C7800
7E60607C60607E00
7E60607C60606000
3C66606E66663C00
6666667E66666600
AA55AA55AA55AA55
0F0F0F0FF0F0F0F0
8040201008040201
3C42A581A599423C
FF818181818181FF
181818FF18181818

// File: all.f
src/text_area_pkg.sv
src/text_regs.sv
src/color_palette.sv
src/cell_ram.sv
src/scroll_mapper.sv
src/glyph_shader.sv
src/alpha_blender.sv
src/text_area.sv
bench/tb_text_area.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_text_area -f all.f -o Vtb_text_area
# font.hex is loaded by name, so the simulation runs next to it
out=$(cd src && ../obj_dir/Vtb_text_area)
echo "$out"
echo "$out" | grep -q "Everything OK"

// File: bench/tb_text_area.sv
`timescale 1ns/10ps

module tb_text_area import text_area_pkg::*; ();

    localparam int CLK_PERIOD  = 8;
    localparam int REG_ROUNDS  = 8;
    localparam int REG_WRITES  = 40;
    localparam int CELL_WRITES = 150;
    localparam int CELL_READS  = 100;
    localparam int BURSTS      = 20;
    localparam int BURST_LEN   = 64;

    // upper bounds on the cycles spent by each test
    localparam int TOTAL_CYCLES = 8 + 48
        + REG_ROUNDS * (REG_WRITES + 64)
        + CELL_COLS * (1 + CELL_ROWS * 4) + CELL_WRITES * 16 + CELL_READS * 12
        + 2 * BURSTS * (8 + BURST_LEN + 4);
    localparam int WATCHDOG_NS = TOTAL_CYCLES * CLK_PERIOD + TOTAL_CYCLES * CLK_PERIOD / 4;

    logic       i_rst = 1'b0;
    logic       i_wr;
    logic       i_write;
    logic       i_rd;
    bus_addr_t  i_addr;
    logic [7:0] i_data;
    logic [8:0] i_scan_row;
    logic [9:0] i_scan_column;
    color_t     i_bg_color;
    logic [7:0] o_data;
    color_t     o_color;

    int seed = 9624;
    int bus_errors = 0;
    int color_errors = 0;
    int cell_errors = 0;

    // model state
    color_t      pal_m [0:15];
    logic [63:0] font_m [0:15];
    logic [15:0] cells_m [0:CELL_COLS*CELL_ROWS-1];
    scroll_x_t   sx_m;
    scroll_y_t   sy_m;
    logic [5:0]  crow_m;
    logic [6:0]  ccol_m;
    logic [15:0] staged_m;
    logic [15:0] readback_m;
    alpha_t      alpha_m;

    text_area i_text_area (
        .i_rst         (i_rst),
        .i_wr          (i_wr),
        .i_write       (i_write),
        .i_rd          (i_rd),
        .i_addr        (i_addr),
        .i_data        (i_data),
        .i_scan_row    (i_scan_row),
        .i_scan_column (i_scan_column),
        .i_bg_color    (i_bg_color),
        .o_data        (o_data),
        .o_color       (o_color)
    );

    always #(CLK_PERIOD / 2) i_rst = ~i_rst;

    function automatic int unsigned rand_below(input int unsigned n);
        int unsigned r;
        r = $unsigned($random(seed));
        return r % n;
    endfunction

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            bus_errors++;
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_color(input string name, input color_t exp, input color_t act);
        if (act !== exp) begin
            color_errors++;
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_cell(input string name, input cell_word_t exp, input cell_word_t act);
        if (act !== exp) begin
            cell_errors++;
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic reset_model();
        pal_m = '{12'h000, 12'h00A, 12'h0A0, 12'h0AA, 12'hA00, 12'hA0A, 12'hA50, 12'hAAA,
                  12'h555, 12'h55F, 12'h5F5, 12'h5FF, 12'hF55, 12'hF5F, 12'hFF5, 12'hFFF};
        sx_m       = '0;
        sy_m       = '0;
        crow_m     = '0;
        ccol_m     = '0;
        staged_m   = '0;
        readback_m = '0;
        alpha_m    = 3'd6;
    endtask

    task automatic model_write(input bus_addr_t addr, input logic [7:0] data);
        if (addr < REG_SCROLL_X_LO) begin
            // odd address is the red lane
            if (addr[0]) begin
                pal_m[addr[4:1]][11:8] = data[3:0];
            end else begin
                pal_m[addr[4:1]][7:0] = data;
            end
        end else begin
            case (addr)
                REG_SCROLL_X_LO: sx_m[7:0] = data;
                REG_SCROLL_X_HI: sx_m[9:8] = data[1:0];
                REG_SCROLL_Y_LO: sy_m[7:0] = data;
                REG_SCROLL_Y_HI: sy_m[8] = data[0];
                REG_CURSOR_ROW:  crow_m = data[5:0];
                REG_CURSOR_COL:  ccol_m = data[6:0];
                REG_CELL_CODE:   staged_m[7:0] = data;
                REG_CELL_COLORS: staged_m[15:8] = data;
                REG_CELL_FG:     staged_m[15:12] = data[3:0];
                REG_CELL_BG:     staged_m[11:8] = data[3:0];
                REG_CELL_ACCESS: begin
                    if (ccol_m < 7'd84) begin
                        cells_m[{ccol_m, crow_m}] = staged_m;
                    end
                end
                REG_ALPHA:       alpha_m = data[2:0];
                default: ;
            endcase
        end
    endtask

    function automatic logic [7:0] model_read(input bus_addr_t addr);
        logic [7:0] v;
        v = 8'h00;
        if (addr < REG_SCROLL_X_LO) begin
            if (addr[0]) begin
                v = {4'h0, pal_m[addr[4:1]][11:8]};
            end else begin
                v = pal_m[addr[4:1]][7:0];
            end
        end else begin
            case (addr)
                REG_SCROLL_X_LO: v = sx_m[7:0];
                REG_SCROLL_X_HI: v = {6'h0, sx_m[9:8]};
                REG_SCROLL_Y_LO: v = sy_m[7:0];
                REG_SCROLL_Y_HI: v = {7'h0, sy_m[8]};
                REG_CURSOR_ROW:  v = {2'h0, crow_m};
                REG_CURSOR_COL:  v = {1'b0, ccol_m};
                REG_CELL_CODE:   v = readback_m[7:0];
                REG_CELL_COLORS: v = readback_m[15:8];
                REG_CELL_FG:     v = {4'h0, readback_m[15:12]};
                REG_CELL_BG:     v = {4'h0, readback_m[11:8]};
                REG_ALPHA:       v = {5'h0, alpha_m};
                default:         v = 8'h00;
            endcase
        end
        return v;
    endfunction

    function automatic logic [3:0] mix_nibble(input logic [3:0] c, input logic [3:0] b,
                                              input int w);
        int s;
        s = int'(c) * w + int'(b) * (8 - w);
        return 4'(s / 8);
    endfunction

    function automatic color_t expected_pixel(input logic [8:0] srow, input logic [9:0] scol,
                                              input color_t bg);
        int          col;
        int          row;
        int          w;
        logic [15:0] word;
        logic [63:0] glyph;
        logic        bit_on;
        color_t      cell_color;
        col = int'(scol) + int'(sx_m);
        if (col >= WRAP_X) begin
            col = col - WRAP_X;
        end
        row = (int'(srow) + int'(sy_m)) % WRAP_Y;
        word = cells_m[{7'(col / 8), 6'(row / 8)}];
        glyph = font_m[word[3:0]];
        bit_on = glyph[6'(63 - ((row % 8) * 8 + col % 8))];
        cell_color = bit_on ? pal_m[word[15:12]] : pal_m[word[11:8]];
        w = (alpha_m >= 3'd6) ? 8 : int'(alpha_m);
        return {mix_nibble(cell_color[11:8], bg[11:8], w),
                mix_nibble(cell_color[7:4], bg[7:4], w),
                mix_nibble(cell_color[3:0], bg[3:0], w)};
    endfunction

    // bus tasks start and end on a falling edge
    task automatic bus_write(input bus_addr_t addr, input logic [7:0] data);
        i_write = 1'b1;
        i_addr  = addr;
        i_data  = data;
        model_write(addr, data);
        @(negedge i_rst);
        i_write = 1'b0;
    endtask

    task automatic bus_read(input bus_addr_t addr, output logic [7:0] data);
        i_rd   = 1'b1;
        i_addr = addr;
        @(negedge i_rst);
        i_rd = 1'b0;
        data = o_data;
    endtask

    task automatic check_reg(input bus_addr_t addr);
        logic [7:0] got;
        bus_read(addr, got);
        check_byte($sformatf("o_data@%02h", addr), model_read(addr), got);
    endtask

    task automatic verify_cell();
        logic [7:0] got;
        cell_word_t word;
        bus_read(REG_CELL_ACCESS, got);
        check_byte("o_data@2a", 8'h00, got);
        readback_m = cells_m[{ccol_m, crow_m}];
        repeat (3) @(negedge i_rst);
        bus_read(REG_CELL_CODE, got);
        word.bytes.code = got;
        bus_read(REG_CELL_COLORS, got);
        word.bytes.colors = got;
        check_cell($sformatf("cell word %0d/%0d", ccol_m, crow_m), readback_m, word);
        check_reg(REG_CELL_FG);
        check_reg(REG_CELL_BG);
    endtask

    task automatic test_reset_values();
        for (int a = 0; a < 44; a++) begin
            if (a != 42) begin
                check_reg(6'(a));
            end
        end
    endtask

    task automatic test_register_access();
        bus_addr_t addr;
        for (int r = 0; r < REG_ROUNDS; r++) begin
            for (int k = 0; k < REG_WRITES; k++) begin
                case (rand_below(4))
                    0: addr = 6'(rand_below(32));
                    1: addr = 6'(32 + rand_below(6));
                    2: addr = REG_ALPHA;
                    default: addr = 6'(44 + rand_below(20));
                endcase
                bus_write(addr, 8'(rand_below(256)));
            end
            // 0x2a is left out, a read there starts a cell fetch
            for (int a = 0; a < 64; a++) begin
                if (a != 42) begin
                    check_reg(6'(a));
                end
            end
        end
    endtask

    task automatic test_cell_access();
        // every cell gets a known word before any pixel is drawn
        for (int c = 0; c < CELL_COLS; c++) begin
            bus_write(REG_CURSOR_COL, 8'(c));
            for (int r = 0; r < CELL_ROWS; r++) begin
                bus_write(REG_CURSOR_ROW, 8'(r));
                bus_write(REG_CELL_CODE, 8'(rand_below(256)));
                bus_write(REG_CELL_COLORS, 8'(rand_below(256)));
                bus_write(REG_CELL_ACCESS, 8'h00);
            end
        end
        for (int k = 0; k < CELL_WRITES; k++) begin
            bus_write(REG_CURSOR_COL, 8'(rand_below(CELL_COLS)));
            bus_write(REG_CURSOR_ROW, 8'(rand_below(256)));
            case (rand_below(3))
                0: begin
                    bus_write(REG_CELL_CODE, 8'(rand_below(256)));
                    bus_write(REG_CELL_COLORS, 8'(rand_below(256)));
                end
                1: begin
                    bus_write(REG_CELL_FG, 8'(rand_below(256)));
                    bus_write(REG_CELL_BG, 8'(rand_below(256)));
                    bus_write(REG_CELL_CODE, 8'(rand_below(256)));
                end
                default: begin
                    // partial update, the rest of the staged word carries over
                    for (int f = 0; f < 4; f++) begin
                        if (rand_below(2) == 1) begin
                            bus_write(6'(38 + f), 8'(rand_below(256)));
                        end
                    end
                end
            endcase
            bus_write(REG_CELL_ACCESS, 8'(rand_below(256)));
            verify_cell();
        end
        for (int k = 0; k < CELL_READS; k++) begin
            bus_write(REG_CURSOR_COL, 8'(rand_below(CELL_COLS)));
            bus_write(REG_CURSOR_ROW, 8'(rand_below(CELL_ROWS)));
            verify_cell();
        end
    endtask

    task automatic run_burst();
        color_t     exp_q [$];
        color_t     exp;
        logic [8:0] srow;
        logic [9:0] scol;
        color_t     bg;
        for (int n = 0; n < BURST_LEN + 4; n++) begin
            // result of the sample driven four falling edges ago
            if (n >= 4) begin
                exp = exp_q.pop_front();
                check_color("o_color", exp, o_color);
            end
            if (n < BURST_LEN) begin
                srow = 9'(rand_below(480));
                scol = 10'(rand_below(640));
                bg   = 12'(rand_below(4096));
                i_scan_row    = srow;
                i_scan_column = scol;
                i_bg_color    = bg;
                exp_q.push_back(expected_pixel(srow, scol, bg));
            end
            @(negedge i_rst);
        end
    endtask

    task automatic test_pixels(input logic vary_alpha);
        scroll_x_t sx;
        scroll_y_t sy;
        for (int b = 0; b < BURSTS; b++) begin
            // even bursts push most column sums past the wrap
            sx = (b % 2 == 0) ? 10'(600 + rand_below(72)) : 10'(rand_below(WRAP_X));
            sy = 9'(rand_below(WRAP_Y));
            bus_write(REG_SCROLL_X_LO, sx[7:0]);
            bus_write(REG_SCROLL_X_HI, {6'h0, sx[9:8]});
            bus_write(REG_SCROLL_Y_LO, sy[7:0]);
            bus_write(REG_SCROLL_Y_HI, {7'h0, sy[8]});
            if (vary_alpha) begin
                bus_write(REG_ALPHA, 8'(rand_below(256)));
                bus_write(6'(rand_below(32)), 8'(rand_below(256)));
            end else begin
                bus_write(REG_ALPHA, 8'h06);
            end
            run_burst();
        end
    endtask

    initial begin
        i_wr          = 1'b1;
        i_write       = 1'b0;
        i_rd          = 1'b0;
        i_addr        = '0;
        i_data        = '0;
        i_scan_row    = '0;
        i_scan_column = '0;
        i_bg_color    = '0;
        $readmemh(FONT_FILE, font_m);
        reset_model();
        repeat (3) @(posedge i_rst);
        @(negedge i_rst);
        i_wr = 1'b0;
        check_byte("o_data", 8'h00, o_data);
        check_color("o_color", 12'h000, o_color);

        test_reset_values();
        test_register_access();
        test_cell_access();
        test_pixels(1'b0);
        test_pixels(1'b1);

        $display("errors: bus %0d, color %0d, cell %0d", bus_errors, color_errors, cell_errors);
        if (bus_errors + color_errors + cell_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

endmodule

// File: src/text_area.sv
`timescale 1ns/10ps

module text_area import text_area_pkg::*; (
    input  logic       i_rst,
    input  logic       i_wr,
    input  logic       i_write,
    input  logic       i_rd,
    input  bus_addr_t  i_addr,
    input  logic [7:0] i_data,
    input  logic [8:0] i_scan_row,
    input  logic [9:0] i_scan_column,
    input  color_t     i_bg_color,
    output logic [7:0] o_data,
    output color_t     o_color
);

    // bus side
    logic       pal_wr_lo;
    logic       pal_wr_hi;
    pal_index_t pal_index;
    logic [7:0] pal_data;
    color_t     pal_bus_color;
    logic       cell_wr;
    cell_addr_t cell_addr;
    cell_word_t cell_wr_word;
    cell_word_t cell_rd_word;
    scroll_x_t  scroll_x;
    scroll_y_t  scroll_y;
    alpha_t     alpha;

    // pixel side
    cell_addr_t pix_cell_addr;
    logic [2:0] pix_row;
    logic [2:0] pix_col;
    cell_word_t pix_cell;
    pal_index_t fg_index;
    pal_index_t bg_index;
    color_t     fg_color;
    color_t     bg_color;
    color_t     cell_color;

    text_regs u_text_regs (
        .i_rst           (i_rst),
        .i_wr            (i_wr),
        .i_write         (i_write),
        .i_rd            (i_rd),
        .i_addr          (i_addr),
        .i_data          (i_data),
        .i_pal_bus_color (pal_bus_color),
        .i_cell_rd_word  (cell_rd_word),
        .o_data          (o_data),
        .o_pal_wr_lo     (pal_wr_lo),
        .o_pal_wr_hi     (pal_wr_hi),
        .o_pal_index     (pal_index),
        .o_pal_data      (pal_data),
        .o_cell_wr       (cell_wr),
        .o_cell_addr     (cell_addr),
        .o_cell_wr_word  (cell_wr_word),
        .o_scroll_x      (scroll_x),
        .o_scroll_y      (scroll_y),
        .o_alpha         (alpha)
    );

    color_palette u_color_palette (
        .i_rst       (i_rst),
        .i_wr        (i_wr),
        .i_wr_lo     (pal_wr_lo),
        .i_wr_hi     (pal_wr_hi),
        .i_index     (pal_index),
        .i_data      (pal_data),
        .i_fg_index  (fg_index),
        .i_bg_index  (bg_index),
        .o_bus_color (pal_bus_color),
        .o_fg_color  (fg_color),
        .o_bg_color  (bg_color)
    );

    cell_ram u_cell_ram (
        .i_rst    (i_rst),
        .i_a_wr   (cell_wr),
        .i_a_addr (cell_addr),
        .i_a_word (cell_wr_word),
        .i_b_addr (pix_cell_addr),
        .o_a_word (cell_rd_word),
        .o_b_word (pix_cell)
    );

    scroll_mapper u_scroll_mapper (
        .i_rst         (i_rst),
        .i_wr          (i_wr),
        .i_scan_row    (i_scan_row),
        .i_scan_column (i_scan_column),
        .i_scroll_x    (scroll_x),
        .i_scroll_y    (scroll_y),
        .o_cell_addr   (pix_cell_addr),
        .o_pix_row     (pix_row),
        .o_pix_col     (pix_col)
    );

    glyph_shader u_glyph_shader (
        .i_rst      (i_rst),
        .i_wr       (i_wr),
        .i_cell     (pix_cell),
        .i_pix_row  (pix_row),
        .i_pix_col  (pix_col),
        .i_fg_color (fg_color),
        .i_bg_color (bg_color),
        .o_fg_index (fg_index),
        .o_bg_index (bg_index),
        .o_color    (cell_color)
    );

    alpha_blender u_alpha_blender (
        .i_rst      (i_rst),
        .i_wr       (i_wr),
        .i_bg_color (i_bg_color),
        .i_fg_color (cell_color),
        .i_alpha    (alpha),
        .o_color    (o_color)
    );

endmodule

// File: src/alpha_blender.sv
`timescale 1ns/10ps

module alpha_blender import text_area_pkg::*; (
    input  logic   i_rst,
    input  logic   i_wr,
    input  color_t i_bg_color,
    input  color_t i_fg_color,
    input  alpha_t i_alpha,
    output color_t o_color
);

    color_t     bg_d1;
    color_t     bg_d2;
    color_t     bg_d3;
    logic [3:0] weight;

    // weighted sum over eighths with the remainder dropped
    function automatic logic [3:0] blend_nibble(input logic [3:0] fg, input logic [3:0] bg,
                                                input logic [3:0] w);
        logic [7:0] acc;
        acc = {4'b0, fg} * {4'b0, w} + {4'b0, bg} * (8'd8 - {4'b0, w});
        return acc[6:3];
    endfunction

    // 6 and 7 both saturate to full weight
    assign weight = (i_alpha >= 3'd6) ? 4'd8 : {1'b0, i_alpha};

    always_ff @(posedge i_rst or posedge i_wr) begin
        if (i_wr) begin
            bg_d1   <= '0;
            bg_d2   <= '0;
            bg_d3   <= '0;
            o_color <= '0;
        end else begin
            // three stages to meet the shaded cell color
            bg_d1   <= i_bg_color;
            bg_d2   <= bg_d1;
            bg_d3   <= bg_d2;
            o_color <= {blend_nibble(i_fg_color[11:8], bg_d3[11:8], weight),
                        blend_nibble(i_fg_color[7:4], bg_d3[7:4], weight),
                        blend_nibble(i_fg_color[3:0], bg_d3[3:0], weight)};
        end
    end

endmodule

// File: src/glyph_shader.sv
`timescale 1ns/10ps

module glyph_shader import text_area_pkg::*; (
    input  logic       i_rst,
    input  logic       i_wr,
    input  cell_word_t i_cell,
    input  logic [2:0] i_pix_row,
    input  logic [2:0] i_pix_col,
    input  color_t     i_fg_color,
    input  color_t     i_bg_color,
    output pal_index_t o_fg_index,
    output pal_index_t o_bg_index,
    output color_t     o_color
);

    // row 0 in the top byte, leftmost pixel is the high bit
    logic [63:0] font_rom [0:15];
    logic [2:0]  pix_row_d;
    logic [2:0]  pix_col_d;
    logic [63:0] glyph;
    logic        pix_on;

    initial begin
        $readmemh(FONT_FILE, font_rom);
    end

    // palette lookup happens in color_palette
    assign o_fg_index = i_cell.fields.fg_index;
    assign o_bg_index = i_cell.fields.bg_index;

    // only the low nibble of the code picks a glyph
    assign glyph  = font_rom[i_cell.fields.char_code[3:0]];
    assign pix_on = glyph[6'd63 - {pix_row_d, pix_col_d}];

    always_ff @(posedge i_rst or posedge i_wr) begin
        if (i_wr) begin
            pix_row_d <= '0;
            pix_col_d <= '0;
            o_color   <= '0;
        end else begin
            // line up with the word coming out of the cell RAM
            pix_row_d <= i_pix_row;
            pix_col_d <= i_pix_col;
            o_color   <= pix_on ? i_fg_color : i_bg_color;
        end
    end

endmodule

// File: src/scroll_mapper.sv
`timescale 1ns/10ps

module scroll_mapper import text_area_pkg::*; (
    input  logic       i_rst,
    input  logic       i_wr,
    input  logic [8:0] i_scan_row,
    input  logic [9:0] i_scan_column,
    input  scroll_x_t  i_scroll_x,
    input  scroll_y_t  i_scroll_y,
    output cell_addr_t o_cell_addr,
    output logic [2:0] o_pix_row,
    output logic [2:0] o_pix_col
);

    logic [10:0] col_sum;
    logic [10:0] col_wrap;
    logic [9:0]  row_sum;
    logic [9:0]  row_wrap;

    // one subtraction is enough for in-range scan and scroll values
    assign col_sum  = {1'b0, i_scan_column} + {1'b0, i_scroll_x};
    assign col_wrap = (col_sum >= 11'(WRAP_X)) ? col_sum - 11'(WRAP_X) : col_sum;
    assign row_sum  = {1'b0, i_scan_row} + {1'b0, i_scroll_y};
    assign row_wrap = (row_sum >= 10'(WRAP_Y)) ? row_sum - 10'(WRAP_Y) : row_sum;

    always_ff @(posedge i_rst or posedge i_wr) begin
        if (i_wr) begin
            o_cell_addr <= '0;
            o_pix_row   <= '0;
            o_pix_col   <= '0;
        end else begin
            o_cell_addr <= {col_wrap[9:3], row_wrap[8:3]};
            o_pix_row   <= row_wrap[2:0];
            o_pix_col   <= col_wrap[2:0];
        end
    end

endmodule

// File: src/cell_ram.sv
`timescale 1ns/10ps

module cell_ram import text_area_pkg::*; (
    input  logic       i_rst,
    input  logic       i_a_wr,
    input  cell_addr_t i_a_addr,
    input  cell_word_t i_a_word,
    input  cell_addr_t i_b_addr,
    output cell_word_t o_a_word,
    output cell_word_t o_b_word
);

    // address is {column, row}, so 84 columns of 64 rows fill it exactly
    cell_word_t mem [0:CELL_COLS*CELL_ROWS-1];

    // port A, bus side, read-first
    always_ff @(posedge i_rst) begin
        if (i_a_wr) begin
            mem[i_a_addr] <= i_a_word;
        end
        o_a_word <= mem[i_a_addr];
    end

    // port B, pixel fetch
    always_ff @(posedge i_rst) begin
        o_b_word <= mem[i_b_addr];
    end

endmodule

// File: src/color_palette.sv
`timescale 1ns/10ps

module color_palette import text_area_pkg::*; (
    input  logic       i_rst,
    input  logic       i_wr,
    input  logic       i_wr_lo,
    input  logic       i_wr_hi,
    input  pal_index_t i_index,
    input  logic [7:0] i_data,
    input  pal_index_t i_fg_index,
    input  pal_index_t i_bg_index,
    output color_t     o_bus_color,
    output color_t     o_fg_color,
    output color_t     o_bg_color
);

    color_t pal [0:15];

    always_ff @(posedge i_rst or posedge i_wr) begin
        if (i_wr) begin
            for (int i = 0; i < 16; i++) begin
                pal[i] <= EGA_PALETTE[i];
            end
        end else begin
            // low lane is green and blue
            if (i_wr_lo) begin
                pal[i_index][7:0] <= i_data;
            end
            // high lane is red only
            if (i_wr_hi) begin
                pal[i_index][11:8] <= i_data[3:0];
            end
        end
    end

    // three independent combinational read ports
    assign o_bus_color = pal[i_index];
    assign o_fg_color  = pal[i_fg_index];
    assign o_bg_color  = pal[i_bg_index];

endmodule

// File: src/text_regs.sv
`timescale 1ns/10ps

module text_regs import text_area_pkg::*; (
    input  logic       i_rst,
    input  logic       i_wr,
    input  logic       i_write,
    input  logic       i_rd,
    input  bus_addr_t  i_addr,
    input  logic [7:0] i_data,
    input  color_t     i_pal_bus_color,
    input  cell_word_t i_cell_rd_word,
    output logic [7:0] o_data,
    output logic       o_pal_wr_lo,
    output logic       o_pal_wr_hi,
    output pal_index_t o_pal_index,
    output logic [7:0] o_pal_data,
    output logic       o_cell_wr,
    output cell_addr_t o_cell_addr,
    output cell_word_t o_cell_wr_word,
    output scroll_x_t  o_scroll_x,
    output scroll_y_t  o_scroll_y,
    output alpha_t     o_alpha
);

    scroll_x_t  scroll_x;
    scroll_y_t  scroll_y;
    logic [5:0] cursor_row;
    logic [6:0] cursor_col;
    cell_word_t staged;
    cell_word_t readback;
    alpha_t     alpha;
    logic       cell_rd_d;
    logic       pal_sel;
    bus_addr_t  pal_off;
    logic [7:0] rd_mux;

    // palette occupies the first 32 addresses, two per entry
    assign pal_sel     = (i_addr < REG_SCROLL_X_LO);
    assign pal_off     = i_addr - REG_PAL_BASE;
    assign o_pal_index = pal_off[4:1];
    assign o_pal_data  = i_data;
    assign o_pal_wr_lo = i_write && pal_sel && !pal_off[0];
    assign o_pal_wr_hi = i_write && pal_sel && pal_off[0];

    // cell write goes straight to the RAM at the cursor
    assign o_cell_wr      = i_write && (i_addr == REG_CELL_ACCESS);
    assign o_cell_addr    = {cursor_col, cursor_row};
    assign o_cell_wr_word = staged;

    assign o_scroll_x = scroll_x;
    assign o_scroll_y = scroll_y;
    assign o_alpha    = alpha;

    // read-back value for the addressed register
    always_comb begin
        rd_mux = '0;
        if (pal_sel) begin
            // odd address holds red in the low nibble
            if (pal_off[0]) begin
                rd_mux = {4'b0, i_pal_bus_color[11:8]};
            end else begin
                rd_mux = i_pal_bus_color[7:0];
            end
        end else begin
            case (i_addr)
                REG_SCROLL_X_LO: rd_mux = scroll_x[7:0];
                REG_SCROLL_X_HI: rd_mux = {6'b0, scroll_x[9:8]};
                REG_SCROLL_Y_LO: rd_mux = scroll_y[7:0];
                REG_SCROLL_Y_HI: rd_mux = {7'b0, scroll_y[8]};
                REG_CURSOR_ROW:  rd_mux = {2'b0, cursor_row};
                REG_CURSOR_COL:  rd_mux = {1'b0, cursor_col};
                REG_CELL_CODE:   rd_mux = readback.bytes.code;
                REG_CELL_COLORS: rd_mux = readback.bytes.colors;
                REG_CELL_FG:     rd_mux = {4'b0, readback.fields.fg_index};
                REG_CELL_BG:     rd_mux = {4'b0, readback.fields.bg_index};
                REG_ALPHA:       rd_mux = {5'b0, alpha};
                default:         rd_mux = '0;
            endcase
        end
    end

    always_ff @(posedge i_rst or posedge i_wr) begin
        if (i_wr) begin
            o_data     <= '0;
            scroll_x   <= '0;
            scroll_y   <= '0;
            cursor_row <= '0;
            cursor_col <= '0;
            staged     <= '0;
            readback   <= '0;
            alpha      <= ALPHA_RESET;
            cell_rd_d  <= 1'b0;
        end else begin
            // port A output is valid one edge after the strobe
            cell_rd_d <= i_rd && (i_addr == REG_CELL_ACCESS);
            if (cell_rd_d) begin
                readback <= i_cell_rd_word;
            end

            if (i_rd) begin
                o_data <= rd_mux;
            end

            if (i_write) begin
                case (i_addr)
                    REG_SCROLL_X_LO: scroll_x[7:0] <= i_data;
                    REG_SCROLL_X_HI: scroll_x[9:8] <= i_data[1:0];
                    REG_SCROLL_Y_LO: scroll_y[7:0] <= i_data;
                    REG_SCROLL_Y_HI: scroll_y[8] <= i_data[0];
                    REG_CURSOR_ROW:  cursor_row <= i_data[5:0];
                    REG_CURSOR_COL:  cursor_col <= i_data[6:0];
                    REG_CELL_CODE:   staged.bytes.code <= i_data;
                    REG_CELL_COLORS: staged.bytes.colors <= i_data;
                    REG_CELL_FG:     staged.fields.fg_index <= i_data[3:0];
                    REG_CELL_BG:     staged.fields.bg_index <= i_data[3:0];
                    REG_ALPHA:       alpha <= i_data[2:0];
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: src/text_area_pkg.sv
package text_area_pkg;

    // scalar types shared across the design
    typedef logic [11:0] color_t;
    typedef logic [3:0]  pal_index_t;
    typedef logic [5:0]  bus_addr_t;
    typedef logic [12:0] cell_addr_t;
    typedef logic [9:0]  scroll_x_t;
    typedef logic [8:0]  scroll_y_t;
    typedef logic [2:0]  alpha_t;

    // cell grid and scroll wrap limits
    localparam int CELL_COLS = 84;
    localparam int CELL_ROWS = 64;
    localparam int WRAP_X    = 672;
    localparam int WRAP_Y    = 512;

    // 6 and 7 both mean fully opaque
    localparam alpha_t ALPHA_RESET = 3'd6;

    // field view of a cell word
    typedef struct packed {
        pal_index_t  fg_index;
        pal_index_t  bg_index;
        logic [7:0]  char_code;
    } cell_fields_t;

    // byte view, colors byte on top
    typedef struct packed {
        logic [7:0] colors;
        logic [7:0] code;
    } cell_bytes_t;

    typedef union packed {
        cell_fields_t fields;
        cell_bytes_t  bytes;
    } cell_word_t;

    // register map
    localparam bus_addr_t REG_PAL_BASE    = 6'h00;
    localparam bus_addr_t REG_SCROLL_X_LO = 6'h20;
    localparam bus_addr_t REG_SCROLL_X_HI = 6'h21;
    localparam bus_addr_t REG_SCROLL_Y_LO = 6'h22;
    localparam bus_addr_t REG_SCROLL_Y_HI = 6'h23;
    localparam bus_addr_t REG_CURSOR_ROW  = 6'h24;
    localparam bus_addr_t REG_CURSOR_COL  = 6'h25;
    localparam bus_addr_t REG_CELL_CODE   = 6'h26;
    localparam bus_addr_t REG_CELL_COLORS = 6'h27;
    localparam bus_addr_t REG_CELL_FG     = 6'h28;
    localparam bus_addr_t REG_CELL_BG     = 6'h29;
    localparam bus_addr_t REG_CELL_ACCESS = 6'h2A;
    localparam bus_addr_t REG_ALPHA       = 6'h2B;

    // glyph bitmaps, one 64-bit word per glyph
    localparam string FONT_FILE = "font.hex";

    // standard EGA colors, 12-bit RGB
    localparam color_t EGA_PALETTE [0:15] = '{
        12'h000, 12'h00A, 12'h0A0, 12'h0AA,
        12'hA00, 12'hA0A, 12'hA50, 12'hAAA,
        12'h555, 12'h55F, 12'h5F5, 12'h5FF,
        12'hF55, 12'hF5F, 12'hFF5, 12'hFFF
    };

endpackage
